/* common/l2_mem_pkg.sv */
package l2_mem_pkg;

    // Line and beat geometry
    localparam int LINE_W     = 512;
    localparam int WORD_W     = 64;
    localparam int BEATS      = 4;
    localparam int BEAT_W     = 2;

    // L2 address fields
    localparam int TAG_W      = 16;
    localparam int INDEX_W    = 10;

    // Word address into memory: tag low bits, index, beat
    localparam int MEM_ADDR_W = 16;
    localparam int TAG_LOW_W  = MEM_ADDR_W - INDEX_W - BEAT_W;
    localparam int MEM_WORDS  = 1 << MEM_ADDR_W;

    typedef logic [LINE_W-1:0]     line_t;
    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [TAG_W-1:0]      tag_t;
    typedef logic [INDEX_W-1:0]    index_t;
    typedef logic [BEAT_W-1:0]     beat_t;
    typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

    // Request from the L2 side, one line at a time
    typedef struct packed {
        logic   read;
        logic   write;
        tag_t   tag;        // fill tag
        tag_t   write_tag;  // victim tag
        index_t index;
        line_t  write_data;
    } l2_req_t;

    // Word request toward the memory controller
    typedef struct packed {
        logic      rstrobe;
        logic      wstrobe;
        mem_addr_t addr;
        word_t     wdata;
    } mem_req_t;

    // Word response from the memory controller
    typedef struct packed {
        logic  ready;
        logic  complete;
        word_t rdata;
    } mem_rsp_t;

    // Bridge sequencing states
    typedef enum logic [2:0] {
        IDLE,
        WRITE,
        WWAIT,
        READ,
        RWAIT
    } bridge_state_t;

endpackage

/* line_bridge/line_bridge.sv */
`timescale 1ns/1ps

module line_bridge (
    input  logic                 clk_cpu,
    input  logic                 rst_n,
    input  l2_mem_pkg::l2_req_t  req,
    output l2_mem_pkg::mem_req_t mem_req,
    input  l2_mem_pkg::mem_rsp_t mem_rsp,
    output l2_mem_pkg::line_t    read_data,
    output logic                 line_ready,
    output logic                 busy
);

    localparam int WORD_W = l2_mem_pkg::WORD_W;
    localparam l2_mem_pkg::beat_t LAST_BEAT = l2_mem_pkg::beat_t'(l2_mem_pkg::BEATS - 1);

    l2_mem_pkg::bridge_state_t state;
    l2_mem_pkg::l2_req_t       req_q;
    l2_mem_pkg::beat_t         beat_cnt;

    l2_mem_pkg::mem_addr_t     fill_addr;
    l2_mem_pkg::mem_addr_t     wb_addr;
    l2_mem_pkg::word_t         wb_word;

    logic                      req_take;
    logic                      last_beat;

    // New request only counts while idle
    assign req_take  = (state == l2_mem_pkg::IDLE) && (req.read || req.write);
    assign last_beat = (beat_cnt == LAST_BEAT);
    assign busy      = (state != l2_mem_pkg::IDLE);

    // Beat number sits in the lowest address bits
    assign fill_addr = {req_q.tag[l2_mem_pkg::TAG_LOW_W-1:0], req_q.index, beat_cnt};
    assign wb_addr   = {req_q.write_tag[l2_mem_pkg::TAG_LOW_W-1:0], req_q.index, beat_cnt};

    // Slice of the victim line for the current beat
    assign wb_word   = req_q.write_data[beat_cnt*WORD_W +: WORD_W];

    // Hold the whole request so the requester can drop it after one cycle
    always_ff @(posedge clk_cpu) begin
        if (req_take) begin
            req_q <= req;
        end
    end

    // Returned words land in their slice of the line
    // Bits beyond the last beat are never carried and stay zero
    always_ff @(posedge clk_cpu or negedge rst_n) begin
        if (!rst_n) begin
            read_data <= '0;
        end else if (state == l2_mem_pkg::RWAIT && mem_rsp.complete) begin
            read_data[beat_cnt*WORD_W +: WORD_W] <= mem_rsp.rdata;
        end
    end

    always_ff @(posedge clk_cpu or negedge rst_n) begin
        if (!rst_n) begin
            state      <= l2_mem_pkg::IDLE;
            beat_cnt   <= '0;
            mem_req    <= '0;
            line_ready <= 1'b0;
        end else begin
            // Strobes and the done flag are single-cycle pulses
            mem_req.rstrobe <= 1'b0;
            mem_req.wstrobe <= 1'b0;
            line_ready      <= 1'b0;

            case (state)
                l2_mem_pkg::IDLE: begin
                    beat_cnt <= '0;
                    if (req_take) begin
                        // Read wins when both are raised
                        state <= req.read ? l2_mem_pkg::READ : l2_mem_pkg::WRITE;
                    end
                end

                l2_mem_pkg::WRITE: begin
                    if (mem_rsp.ready) begin
                        mem_req.wstrobe <= 1'b1;
                        mem_req.addr    <= wb_addr;
                        mem_req.wdata   <= wb_word;
                        state           <= l2_mem_pkg::WWAIT;
                    end
                end

                l2_mem_pkg::WWAIT: begin
                    if (mem_rsp.complete) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (last_beat) begin
                            state      <= l2_mem_pkg::IDLE;
                            line_ready <= 1'b1;
                        end else begin
                            state <= l2_mem_pkg::WRITE;
                        end
                    end
                end

                l2_mem_pkg::READ: begin
                    if (mem_rsp.ready) begin
                        mem_req.rstrobe <= 1'b1;
                        mem_req.addr    <= fill_addr;
                        state           <= l2_mem_pkg::RWAIT;
                    end
                end

                l2_mem_pkg::RWAIT: begin
                    if (mem_rsp.complete) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (last_beat) begin
                            state      <= l2_mem_pkg::IDLE;
                            line_ready <= 1'b1;
                        end else begin
                            state <= l2_mem_pkg::READ;
                        end
                    end
                end

                default: begin
                    state <= l2_mem_pkg::IDLE;
                end
            endcase
        end
    end

endmodule

/* mem_ctrl/word_mem_ctrl.sv */
`timescale 1ns/1ps

module word_mem_ctrl #(
    parameter int LATENCY = 3
) (
    input  logic                 clk_cpu,
    input  logic                 rst_n,
    input  l2_mem_pkg::mem_req_t mem_req,
    output l2_mem_pkg::mem_rsp_t mem_rsp
);

    // Counter holds LATENCY-1, so one bit is enough for LATENCY of 1
    localparam int CNT_W = (LATENCY > 1) ? $clog2(LATENCY) : 1;

    l2_mem_pkg::word_t     mem [0:l2_mem_pkg::MEM_WORDS-1];

    l2_mem_pkg::mem_addr_t addr_q;
    l2_mem_pkg::word_t     wdata_q;
    logic                  is_write_q;

    logic                  pending;
    logic [CNT_W-1:0]      cnt;
    logic                  strobe;
    logic                  complete;

    initial begin
        for (int i = 0; i < l2_mem_pkg::MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    // A strobe is only taken while no access is in flight
    assign strobe   = !pending && (mem_req.rstrobe || mem_req.wstrobe);

    // Access ends once the counter has run down
    assign complete = pending && (cnt == '0);

    assign mem_rsp.ready    = !pending;
    assign mem_rsp.complete = complete;
    assign mem_rsp.rdata    = mem[addr_q];

    always_ff @(posedge clk_cpu or negedge rst_n) begin
        if (!rst_n) begin
            pending <= 1'b0;
            cnt     <= '0;
        end else if (strobe) begin
            pending <= 1'b1;
            cnt     <= CNT_W'(LATENCY - 1);
        end else if (complete) begin
            // Ready comes back in the next cycle
            pending <= 1'b0;
        end else if (pending) begin
            cnt <= cnt - 1'b1;
        end
    end

    // Latch the access on the strobe
    always_ff @(posedge clk_cpu) begin
        if (strobe) begin
            addr_q     <= mem_req.addr;
            wdata_q    <= mem_req.wdata;
            is_write_q <= mem_req.wstrobe && !mem_req.rstrobe;
        end
    end

    // Write lands at the end of the complete cycle
    always @(posedge clk_cpu) begin
        if (complete && is_write_q) begin
            mem[addr_q] <= wdata_q;
        end
    end

endmodule

/* hdl/l2_mem_top.sv */
`timescale 1ns/1ps

module l2_mem_top #(
    parameter int LATENCY = 3
) (
    input  logic                clk_cpu,
    input  logic                rst_n,
    input  l2_mem_pkg::l2_req_t req,
    output l2_mem_pkg::line_t   read_data,
    output logic                line_ready,
    output logic                busy
);

    // Word channel between bridge and memory
    l2_mem_pkg::mem_req_t mem_req;
    l2_mem_pkg::mem_rsp_t mem_rsp;

    line_bridge line_bridge_inst (
        .clk_cpu    (clk_cpu),
        .rst_n      (rst_n),
        .req        (req),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp),
        .read_data  (read_data),
        .line_ready (line_ready),
        .busy       (busy)
    );

    word_mem_ctrl #(
        .LATENCY (LATENCY)
    ) word_mem_ctrl_inst (
        .clk_cpu (clk_cpu),
        .rst_n   (rst_n),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

endmodule

/* sim/l2_mem_properties.sv */
`timescale 1ns/1ps

module l2_mem_properties (
    input logic                 clk_cpu,
    input logic                 rst_n,
    input l2_mem_pkg::mem_req_t mem_req,
    input l2_mem_pkg::mem_rsp_t mem_rsp,
    input logic                 line_ready
);

    int fail_count = 0;

    // Strobe only while the memory is ready
    assert property (@(posedge clk_cpu) disable iff (!rst_n)
        (mem_req.rstrobe || mem_req.wstrobe) |-> mem_rsp.ready)
    else begin
        $error("strobe given while ready is low");
        fail_count++;
    end

    assert property (@(posedge clk_cpu) disable iff (!rst_n)
        !(mem_req.rstrobe && mem_req.wstrobe))
    else begin
        $error("rstrobe and wstrobe high together");
        fail_count++;
    end

    // Strobes are single-cycle pulses
    assert property (@(posedge clk_cpu) disable iff (!rst_n)
        (mem_req.rstrobe || mem_req.wstrobe) |=> !(mem_req.rstrobe || mem_req.wstrobe))
    else begin
        $error("strobe held longer than one cycle");
        fail_count++;
    end

    assert property (@(posedge clk_cpu) disable iff (!rst_n)
        line_ready |=> !line_ready)
    else begin
        $error("line_ready held longer than one cycle");
        fail_count++;
    end

endmodule

bind line_bridge l2_mem_properties l2_mem_properties_inst (
    .clk_cpu    (clk_cpu),
    .rst_n      (rst_n),
    .mem_req    (mem_req),
    .mem_rsp    (mem_rsp),
    .line_ready (line_ready)
);

/* sim/tb_l2_mem.sv */
`timescale 1ns/1ps

module tb_l2_mem;

    localparam int LATENCY = 3;
    localparam int TIMEOUT = 200;
    localparam int KEY_W   = l2_mem_pkg::TAG_LOW_W + l2_mem_pkg::INDEX_W;
    localparam int WORD_W  = l2_mem_pkg::WORD_W;

    typedef logic [KEY_W-1:0] ref_key_t;

    logic                clk_cpu = 1'b0;
    logic                rst_n;
    l2_mem_pkg::l2_req_t req;
    l2_mem_pkg::line_t   read_data;
    logic                line_ready;
    logic                busy;

    int                  errors = 0;
    logic [63:0]         rng_state = 64'd49;

    // Expected memory contents, one entry per line
    l2_mem_pkg::line_t   ref_lines [ref_key_t];

    l2_mem_top #(
        .LATENCY (LATENCY)
    ) l2_mem_top_inst (
        .clk_cpu    (clk_cpu),
        .rst_n      (rst_n),
        .req        (req),
        .read_data  (read_data),
        .line_ready (line_ready),
        .busy       (busy)
    );

    always #10 clk_cpu = ~clk_cpu;

    function automatic logic [63:0] xorshift64();
        logic [63:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 7);
        x = x ^ (x << 17);
        rng_state = x;
        return x;
    endfunction

    function automatic l2_mem_pkg::line_t random_line();
        l2_mem_pkg::line_t line;
        for (int b = 0; b < 8; b++) begin
            line[b*64 +: 64] = xorshift64();
        end
        return line;
    endfunction

    // Only the low tag bits reach the memory address
    function automatic ref_key_t ref_key(input l2_mem_pkg::tag_t tag,
                                         input l2_mem_pkg::index_t index);
        return {tag[l2_mem_pkg::TAG_LOW_W-1:0], index};
    endfunction

    // Only the first BEATS words of a line travel to memory and back
    function automatic l2_mem_pkg::line_t carried_part(input l2_mem_pkg::line_t line);
        l2_mem_pkg::line_t kept;
        kept = '0;
        for (int b = 0; b < l2_mem_pkg::BEATS; b++) begin
            kept[b*WORD_W +: WORD_W] = line[b*WORD_W +: WORD_W];
        end
        return kept;
    endfunction

    function automatic l2_mem_pkg::line_t ref_get(input l2_mem_pkg::tag_t tag,
                                                  input l2_mem_pkg::index_t index);
        if (ref_lines.exists(ref_key(tag, index))) begin
            return carried_part(ref_lines[ref_key(tag, index)]);
        end
        return '0;
    endfunction

    function automatic l2_mem_pkg::l2_req_t make_req(input logic rd, input logic wr,
                                                     input l2_mem_pkg::tag_t tag,
                                                     input l2_mem_pkg::tag_t write_tag,
                                                     input l2_mem_pkg::index_t index,
                                                     input l2_mem_pkg::line_t data);
        l2_mem_pkg::l2_req_t r;
        r.read       = rd;
        r.write      = wr;
        r.tag        = tag;
        r.write_tag  = write_tag;
        r.index      = index;
        r.write_data = data;
        return r;
    endfunction

    task automatic check_line(input string name, input l2_mem_pkg::line_t exp,
                              input l2_mem_pkg::line_t act);
        if (act !== exp) begin
            $display("error: %s expected 0x%h actual 0x%h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("error: %s expected 0x%h actual 0x%h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input l2_mem_pkg::word_t exp,
                              input l2_mem_pkg::word_t act);
        if (act !== exp) begin
            $display("error: %s expected 0x%h actual 0x%h", name, exp, act);
            errors++;
        end
    endtask

    task automatic pulse_req(input l2_mem_pkg::l2_req_t r);
        @(posedge clk_cpu);
        req <= r;
        @(posedge clk_cpu);
        req <= '0;
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        @(negedge clk_cpu);
        while (busy !== 1'b0 && cycles < TIMEOUT) begin
            @(negedge clk_cpu);
            cycles++;
        end
        if (busy !== 1'b0) begin
            $display("Timed out waiting for the bridge to become idle");
            errors++;
        end
    endtask

    task automatic wait_line();
        int cycles;
        cycles = 0;
        @(negedge clk_cpu);
        while (line_ready !== 1'b1 && cycles < TIMEOUT) begin
            @(negedge clk_cpu);
            cycles++;
        end
        if (line_ready !== 1'b1) begin
            $display("Timed out waiting for line_ready")
;
            errors++;
        end
    endtask

    // The unused tag field points at another line so a mixed-up tag shows
    task automatic send_write(input l2_mem_pkg::tag_t tag, input l2_mem_pkg::index_t index,
                              input l2_mem_pkg::line_t data);
        wait_idle();
        pulse_req(make_req(1'b0, 1'b1, ~tag, tag, index, data));
    endtask

    task automatic send_read(input l2_mem_pkg::tag_t tag, input l2_mem_pkg::index_t index);
        wait_idle();
        pulse_req(make_req(1'b1, 1'b0, tag, tag ^ 16'h0005, index, '0));
    endtask

    task automatic write_line(input l2_mem_pkg::tag_t tag, input l2_mem_pkg::index_t index,
                              input l2_mem_pkg::line_t data);
        ref_lines[ref_key(tag, index)] = data;
        send_write(tag, index, data);
        wait_line();
    endtask

    // Compares the line at line_ready, then names the first bad beat
    task automatic check_read_data(input l2_mem_pkg::line_t exp);
        int bad;
        bad = -1;
        check_line("read_data", exp, read_data);
        for (int b = 0; b < l2_mem_pkg::BEATS; b++) begin
            if (bad < 0 && read_data[b*WORD_W +: WORD_W] !== exp[b*WORD_W +: WORD_W]) begin
                bad = b;
            end
        end
        if (bad >= 0) begin
            check_word($sformatf("read_data[%0d]", bad), exp[bad*WORD_W +: WORD_W],
                       read_data[bad*WORD_W +: WORD_W]);
        end
    endtask

    task automatic read_and_check(input l2_mem_pkg::tag_t tag,
                                  input l2_mem_pkg::index_t index);
        send_read(tag, index);
        wait_line();
        check_read_data(ref_get(tag, index));
    endtask

    task automatic test_reset();
        repeat (8) begin
            @(negedge clk_cpu);
            check_flag("line_ready", 1'b0, line_ready);
            check_flag("busy", 1'b0, busy);
        end
    endtask

    task automatic test_write_read();
        write_line(16'h1234, 10'h0c7, random_line());
        read_and_check(16'h1234, 10'h0c7);
    endtask

    task automatic test_unwritten();
        read_and_check(16'h00a5, 10'h3ff);
        check_line("unwritten line", '0, read_data);
    endtask

    task automatic test_no_alias();
        write_line(16'h0001, 10'h005, random_line());
        write_line(16'h0002, 10'h005, random_line());
        write_line(16'h0001, 10'h006, random_line());
        write_line(16'h0003, 10'h006, random_line());
        read_and_check(16'h0001, 10'h005);
        read_and_check(16'h0002, 10'h005);
        read_and_check(16'h0001, 10'h006);
        read_and_check(16'h0003, 10'h006);
    endtask

    task automatic test_priority_and_busy();
        int extra;
        extra = 0;
        // Both flags raised, memory must not take the new data
        wait_idle();
        pulse_req(make_req(1'b1, 1'b1, 16'h1234, 16'h1234, 10'h0c7, random_line()));
        wait_line();
        check_read_data(ref_get(16'h1234, 10'h0c7));
        read_and_check(16'h1234, 10'h0c7);

        // Second write arrives while the first one is running
        ref_lines[ref_key(16'h0004, 10'h020)] = random_line();
        send_write(16'h0004, 10'h020, ref_lines[ref_key(16'h0004, 10'h020)]);
        pulse_req(make_req(1'b0, 1'b1, ~16'h0005, 16'h0005, 10'h021, random_line()));
        wait_line();
        repeat (40) begin
            @(negedge clk_cpu);
            if (line_ready === 1'b1) begin
                extra++;
            end
        end
        check_flag("extra line_ready", 1'b0, extra != 0);
        read_and_check(16'h0004, 10'h020);
        read_and_check(16'h0005, 10'h021);
    endtask

    task automatic test_random();
        logic [63:0]         r;
        l2_mem_pkg::tag_t    tag;
        l2_mem_pkg::index_t  index;
        for (int i = 0; i < 20; i++) begin
            r     = xorshift64();
            // Few tag and index values so fills hit earlier writebacks
            tag   = r[15:0] & 16'hfff3;
            index = {8'h40, r[17:16]};
            if (r[63]) begin
                write_line(tag, index, random_line());
            end else begin
                read_and_check(tag, index);
            end
        end
    endtask

    initial begin
        req   = '0;
        rst_n = 1'b0;
        repeat (10) @(posedge clk_cpu);
        rst_n <= 1'b1;

        test_reset();
        test_write_read();
        test_unwritten();
        test_no_alias();
        test_priority_and_busy();
        test_random();

        // Protocol assertion failures count as errors too
        errors += l2_mem_top_inst.line_bridge_inst.l2_mem_properties_inst.fail_count;
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* list.f */
common/l2_mem_pkg.sv
line_bridge/line_bridge.sv
mem_ctrl/word_mem_ctrl.sv
hdl/l2_mem_top.sv
sim/l2_mem_properties.sv
sim/tb_l2_mem.sv

/* Makefile */
TOP = tb_l2_mem

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f list.f

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f list.f -o sim_$(TOP)
	@out=$$(./obj_dir/sim_$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Regression passed$$"

clean:
	rm -rf obj_dir
